/* design/mmu_addr_pkg.sv */
package mmu_addr_pkg;

    // address geometry of the Sv32 style translation.
    localparam int VADDR_W     = 32;
    localparam int PADDR_W     = 34;
    localparam int PAGE_OFFSET = 12;

    localparam int VPN_W    = VADDR_W - PAGE_OFFSET;
    localparam int PPN_W    = PADDR_W - PAGE_OFFSET;
    localparam int VPN_LO_W = 10;                      // level 0 page number, dropped by mega pages.

    // tlb geometry.
    localparam int TLB_DEPTH   = 16;
    localparam int IDX_W       = $clog2(TLB_DEPTH);
    localparam int PMP_REGIONS = 4;

    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [VPN_W-1:0]   vpn_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [IDX_W-1:0]   tlb_idx_t;
    typedef logic [1:0]         priv_t;

    // privilege encodings as held in the csr view.
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

endpackage

/* design/tlb_types_pkg.sv */
package tlb_types_pkg;

    import mmu_addr_pkg::*;

    // leaf pte as delivered by the walker.
    typedef struct packed {
        ppn_t ppn;
        logic u;
        logic g;
        logic r;
        logic w;
        logic x;
    } pte_t;

    typedef struct packed {
        vpn_t vpn;
        ppn_t ppn;
        logic mega;         // 4 MiB page.
        logic u;
        logic r;
        logic x;
        logic fault;        // pmp denied read at refill time.
    } tlb_entry_t;

    typedef struct packed {
        logic     we;
        tlb_idx_t idx;
        vaddr_t   vaddr;
        pte_t     pte;
        logic     mega;
    } refill_t;

    typedef struct packed {
        logic   flush;
        logic   flush_all;
        vaddr_t vaddr;
    } fence_t;

    // region covers base <= page < top.
    typedef struct packed {
        ppn_t base;
        ppn_t top;
        logic r;
    } pmp_region_t;

    typedef struct packed {
        priv_t                         priv;
        logic                          satp_on;
        logic                          sum;
        logic                          mxr;
        pmp_region_t [PMP_REGIONS-1:0] pmp;
        ppn_t                          uc_base;
        ppn_t                          uc_top;
    } csr_tlb_t;

    typedef struct packed {
        logic   miss;
        logic   exception;
        logic   uncache;
        paddr_t paddr;
    } tlb_resp_t;

endpackage

/* design/pmp_check.sv */
`timescale 1ns/100ps

module pmp_check
    import mmu_addr_pkg::*, tlb_types_pkg::*;
(
    input  ppn_t                          page,
    input  pmp_region_t [PMP_REGIONS-1:0] regions,
    output logic                          pmp_v,
    output logic                          pmp_r
);

    logic [PMP_REGIONS-1:0] in_range;
    logic [PMP_REGIONS-1:0] allow_r;

    // range compare per region.
    for (genvar i = 0; i < PMP_REGIONS; i++) begin : g_range
        assign in_range[i] = (page >= regions[i].base) && (page < regions[i].top);
        assign allow_r[i]  = regions[i].r;
    end

    // lowest numbered region takes priority.
    always_comb begin
        pmp_v = 1'b0;
        pmp_r = 1'b0;
        for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
            if (in_range[i]) begin
                pmp_v = 1'b1;
                pmp_r = allow_r[i];
            end
        end
    end

endmodule

/* design/tlb_slot.sv */
`timescale 1ns/100ps

module tlb_slot
    import mmu_addr_pkg::*, tlb_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vpn_t       lookup_vpn,
    input  logic       we,
    input  tlb_entry_t wentry,
    input  logic       inval_match,
    input  logic       inval_all,
    output logic       hit,
    output tlb_entry_t entry
);

    logic       valid;
    tlb_entry_t entry_q;
    logic       hi_eq;
    logic       lo_eq;

    assign hi_eq = entry_q.vpn[VPN_W-1:VPN_LO_W] == lookup_vpn[VPN_W-1:VPN_LO_W];
    assign lo_eq = entry_q.vpn[VPN_LO_W-1:0] == lookup_vpn[VPN_LO_W-1:0];
    assign hit   = valid & hi_eq & (entry_q.mega | lo_eq);   // mega ignores level 0.
    assign entry = entry_q;

    always_ff @(posedge clk) begin
        if (we) begin
            entry_q <= wentry;
        end
    end

    // invalidate wins over a write in the same cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (inval_all || (inval_match && hit)) begin
            valid <= 1'b0;
        end else if (we) begin
            valid <= 1'b1;
        end
    end

    a_we_flush_all: assert property (@(posedge clk) disable iff (rst)
        !(we && inval_all));

endmodule

/* design/tlb_hit_select.sv */
`timescale 1ns/100ps

module tlb_hit_select
    import mmu_addr_pkg::*, tlb_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  vaddr_t                     vaddr,
    input  csr_tlb_t                   csr,
    input  logic [TLB_DEPTH-1:0]       hits,
    input  tlb_entry_t [TLB_DEPTH-1:0] entries,
    output tlb_resp_t                  resp
);

    tlb_entry_t hit_entry;
    logic       hit_any;
    logic       bypass;
    logic       mode_exc;
    ppn_t       lookup_ppn;
    paddr_t     next_paddr;
    paddr_t     paddr_q;
    logic       miss_q;
    logic       exc_q;
    ppn_t       resp_page;

    // lowest index wins when slots alias.
    always_comb begin
        hit_any   = 1'b0;
        hit_entry = '0;
        for (int i = TLB_DEPTH - 1; i >= 0; i--) begin
            if (hits[i]) begin
                hit_any   = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    assign bypass = (csr.priv == PRIV_M) | ~csr.satp_on;

    always_comb begin
        lookup_ppn = hit_entry.ppn;
        if (hit_entry.mega) begin
            lookup_ppn[VPN_LO_W-1:0] = vaddr[PAGE_OFFSET +: VPN_LO_W];
        end
    end

    assign mode_exc = ((csr.priv == PRIV_S) & ~csr.sum & hit_entry.u)
                    | ((csr.priv == PRIV_U) & ~hit_entry.u)
                    | (~hit_entry.r & ~(hit_entry.x & csr.mxr))
                    | hit_entry.fault;

    assign next_paddr = bypass ? {{(PADDR_W - VADDR_W){1'b0}}, vaddr}
                               : {lookup_ppn, vaddr[PAGE_OFFSET-1:0]};

    always_ff @(posedge clk) begin
        if (req) begin
            paddr_q <= next_paddr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miss_q <= 1'b0;
            exc_q  <= 1'b0;
        end else begin
            miss_q <= req & ~bypass & ~hit_any;
            exc_q  <= req & ~bypass & hit_any & mode_exc;
        end
    end

    assign resp_page = paddr_q[PADDR_W-1:PAGE_OFFSET];

    assign resp.miss      = miss_q;
    assign resp.exception = exc_q;
    assign resp.uncache   = (resp_page >= csr.uc_base) && (resp_page < csr.uc_top);
    assign resp.paddr     = paddr_q;

endmodule

/* design/tlb_update_ctrl.sv */
`timescale 1ns/100ps

module tlb_update_ctrl
    import mmu_addr_pkg::*, tlb_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  vaddr_t               vaddr,
    input  refill_t              refill,
    input  fence_t               fence,
    input  csr_tlb_t             csr,
    output vpn_t                 lookup_vpn,
    output logic [TLB_DEPTH-1:0] slot_we,
    output tlb_entry_t           slot_entry,
    output logic                 inval_match,
    output logic                 inval_all
);

    typedef enum logic [1:0] {
        IDLE,
        FENCE,
        FENCE_END
    } fence_state_t;

    fence_state_t state;
    vpn_t         fence_vpn;
    logic         pmp_v;
    logic         pmp_r;

    pmp_check u_pmp (
        .page    (refill.pte.ppn),
        .regions (csr.pmp),
        .pmp_v   (pmp_v),
        .pmp_r   (pmp_r)
    );

    always_comb begin
        slot_entry.vpn   = refill.vaddr[VADDR_W-1:PAGE_OFFSET];
        slot_entry.ppn   = refill.pte.ppn;
        slot_entry.mega  = refill.mega;
        slot_entry.u     = refill.pte.u;
        slot_entry.r     = refill.pte.r;
        slot_entry.x     = refill.pte.x;
        slot_entry.fault = pmp_v & ~pmp_r;
    end

    // refills are dropped while a fence is in flight.
    always_comb begin
        slot_we = '0;
        if (refill.we && state == IDLE) begin
            slot_we[refill.idx] = 1'b1;
        end
    end

    assign lookup_vpn = (state != IDLE) ? fence_vpn : vaddr[VADDR_W-1:PAGE_OFFSET];

    always_ff @(posedge clk) begin
        if (state == IDLE && fence.flush) begin
            fence_vpn <= fence.vaddr[VADDR_W-1:PAGE_OFFSET];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            inval_match <= 1'b0;
            inval_all   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fence.flush && fence.flush_all) begin
                        inval_all <= 1'b1;
                        state     <= FENCE_END;
                    end else if (fence.flush) begin
                        state <= FENCE;
                    end
                end
                FENCE: begin
                    inval_match <= 1'b1;    // slots compare against fence_vpn.
                    state       <= FENCE_END;
                end
                FENCE_END: begin
                    inval_match <= 1'b0;
                    inval_all   <= 1'b0;
                    // one more cycle once the strobe has done its work
                    if (!inval_match && !inval_all) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_flush_idle: assert property (@(posedge clk) disable iff (rst)
        fence.flush |-> state == IDLE);

    a_no_req_fence: assert property (@(posedge clk) disable iff (rst)
        req |-> state != FENCE);

endmodule

/* design/l1_tlb.sv */
`timescale 1ns/100ps

module l1_tlb
    import mmu_addr_pkg::*, tlb_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  vaddr_t    vaddr,
    input  refill_t   refill,
    input  fence_t    fence,
    input  csr_tlb_t  csr,
    output tlb_resp_t resp
);

    vpn_t                       lookup_vpn;
    logic [TLB_DEPTH-1:0]       slot_we;
    tlb_entry_t                 slot_entry;
    logic                       inval_match;
    logic                       inval_all;
    logic [TLB_DEPTH-1:0]       hits;
    tlb_entry_t [TLB_DEPTH-1:0] entries;

    tlb_update_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .vaddr       (vaddr),
        .refill      (refill),
        .fence       (fence),
        .csr         (csr),
        .lookup_vpn  (lookup_vpn),
        .slot_we     (slot_we),
        .slot_entry  (slot_entry),
        .inval_match (inval_match),
        .inval_all   (inval_all)
    );

    for (genvar i = 0; i < TLB_DEPTH; i++) begin : g_slot
        tlb_slot u_slot (
            .clk         (clk),
            .rst         (rst),
            .lookup_vpn  (lookup_vpn),
            .we          (slot_we[i]),
            .wentry      (slot_entry),
            .inval_match (inval_match),
            .inval_all   (inval_all),
            .hit         (hits[i]),
            .entry       (entries[i])
        );
    end

    tlb_hit_select u_sel (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .vaddr   (vaddr),
        .csr     (csr),
        .hits    (hits),
        .entries (entries),
        .resp    (resp)
    );

endmodule

/* tb/tb_l1_tlb.sv */
`timescale 1ns/100ps

module tb_l1_tlb
    import mmu_addr_pkg::*, tlb_types_pkg::*;
;

    logic      clk;
    logic      rst;
    logic      req;
    vaddr_t    vaddr;
    refill_t   refill;
    fence_t    fence;
    csr_tlb_t  csr;
    tlb_resp_t resp;

    string lines[$];
    int    cycles;
    int    limit;

    l1_tlb u_dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .vaddr  (vaddr),
        .refill (refill),
        .fence  (fence),
        .csr    (csr),
        .resp   (resp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the command list did not finish", cycles);
            $display("=== FAIL ===");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_lines();
        int    fd;
        string line;
        fd = $fopen("tb/tlb_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/tlb_testdata.txt");
            $display("=== FAIL ===");
            $fatal(1, "missing test data");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_refill(input logic [63:0] idx, input logic [63:0] va,
                                input logic [63:0] ppn, input logic [63:0] u,
                                input logic [63:0] r, input logic [63:0] x,
                                input logic [63:0] mega);
        refill.we      <= 1'b1;
        refill.idx     <= idx[IDX_W-1:0];
        refill.vaddr   <= va[VADDR_W-1:0];
        refill.pte.ppn <= ppn[PPN_W-1:0];
        refill.pte.u   <= u[0];
        refill.pte.g   <= 1'b0;
        refill.pte.r   <= r[0];
        refill.pte.w   <= 1'b0;
        refill.pte.x   <= x[0];
        refill.mega    <= mega[0];
    endtask

    // response is registered at the edge after the request is seen.
    task automatic run_request(input logic [63:0] va, input logic [63:0] e_miss,
                               input logic [63:0] e_exc, input logic [63:0] e_uc,
                               input logic [63:0] e_pa, input int n);
        req   <= 1'b1;
        vaddr <= va[VADDR_W-1:0];
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_val(64'(resp.miss), e_miss, $sformatf("cmd %0d va %h miss", n, va[31:0]));
        check_val(64'(resp.exception), e_exc, $sformatf("cmd %0d va %h exc", n, va[31:0]));
        if (e_miss == 64'd0) begin
            check_val(64'(resp.uncache), e_uc, $sformatf("cmd %0d va %h uncache", n, va[31:0]));
            check_val(64'(resp.paddr), e_pa, $sformatf("cmd %0d va %h paddr", n, va[31:0]));
        end
    endtask

    // optional refill lands while the fence is busy.
    task automatic run_fence(input logic all, input logic [63:0] va, input logic has_w,
                             input logic [63:0] idx, input logic [63:0] wva,
                             input logic [63:0] wppn);
        fence.flush     <= 1'b1;
        fence.flush_all <= all;
        fence.vaddr     <= va[VADDR_W-1:0];
        @(posedge clk);
        fence.flush <= 1'b0;
        if (has_w) begin
            drive_refill(idx, wva, wppn, 64'd0, 64'd1, 64'd0, 64'd0);
        end
        @(posedge clk);
        refill.we <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic exec_line(input string line, input int n);
        logic [63:0] a, b, c, d, e, f, g;
        int          cnt;
        byte         op;
        op  = line.getc(0);
        cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h",
                      a, b, c, d, e, f, g);
        case (op)
            "P": begin
                csr.pmp[a[1:0]].base <= b[PPN_W-1:0];
                csr.pmp[a[1:0]].top  <= c[PPN_W-1:0];
                csr.pmp[a[1:0]].r    <= d[0];
            end
            "C": begin
                csr.priv    <= a[1:0];
                csr.satp_on <= b[0];
                csr.sum     <= c[0];
                csr.mxr     <= d[0];
                csr.uc_base <= e[PPN_W-1:0];
                csr.uc_top  <= f[PPN_W-1:0];
            end
            "W": begin
                drive_refill(a, b, c, d, e, f, g);
                @(posedge clk);
                refill.we <= 1'b0;
            end
            "R": run_request(a, b, c, d, e, n);
            "F": run_fence(1'b0, a, cnt >= 4, b, c, d);
            "A": run_fence(1'b1, 64'd0, cnt >= 3, a, b, c);
            default: begin
                $display("unknown command in test data line: %s", line);
                $display("=== FAIL ===");
                $fatal(1, "bad test data");
            end
        endcase
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        req    = 1'b0;
        vaddr  = '0;
        refill = '0;
        fence  = '0;
        csr    = '0;
        cycles = 0;
        limit  = 1000;
        load_lines();
        limit = lines.size() * 8 + 100;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (lines[n]) begin
            @(posedge clk);
            exec_line(lines[n], n);
        end
        @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tb/tlb_testdata.txt */
# C priv satp sum mxr uc_base uc_top | P region base top r | W idx vaddr ppn u r x mega
# R vaddr miss exc uncache paddr | F vaddr [idx vaddr ppn] | A [idx vaddr ppn], all hex
P 0 00100 00200 0
P 1 00000 00100 1
P 2 00100 00180 1
C 3 1 0 0 20000 20100
R 12345678 0 0 0 012345678
R 20000010 0 0 1 020000010
C 1 0 0 0 20000 20100
R 80001abc 0 0 0 080001abc
C 1 1 0 0 20000 20100
R 40000123 1 0 0 0
W 0 40000000 00300 0 1 0 0
R 40000abc 0 0 0 000300abc
W 1 80400000 12400 0 1 0 1
R 80567def 0 0 0 012567def
R 40001000 1 0 0 0
W 2 00010000 00400 1 1 0 0
R 00010004 0 1 0 000400004
C 1 1 1 0 20000 20100
R 00010004 0 0 0 000400004
C 0 1 0 0 20000 20100
R 00010004 0 0 0 000400004
R 40000abc 0 1 0 000300abc
W 3 00020000 00500 1 0 1 0
R 00020008 0 1 0 000500008
C 0 1 0 1 20000 20100
R 00020008 0 0 0 000500008
R 00030000 1 0 0 0
C 1 1 0 0 20000 20100
W 4 00040000 00150 0 1 0 0
R 00040010 0 1 0 000150010
W 5 00050000 00050 0 1 0 0
R 00050020 0 0 0 000050020
W 6 00060000 20010 0 1 0 0
W 7 00060000 00600 0 1 0 0
R 00060040 0 0 1 020010040
F 00060000 8 00070000 00700
R 00060040 1 0 0 0
R 00070000 1 0 0 0
F 80555000
R 80567def 1 0 0 0
R 40000abc 0 0 0 000300abc
A 9 00090000 00900
R 40000abc 1 0 0 0
R 00090000 1 0 0 0
W 0 40000000 00310 0 1 0 0
R 40000abc 0 0 0 000310abc

/* flist.f */
design/mmu_addr_pkg.sv
design/tlb_types_pkg.sv
design/pmp_check.sv
design/tlb_slot.sv
design/tlb_hit_select.sv
design/tlb_update_ctrl.sv
design/l1_tlb.sv
tb/tb_l1_tlb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_l1_tlb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F -- '$(PASS_MSG)' \
		&& echo "test passed" \
		|| (echo "test failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR)
